//--- common/cpu_pkg.sv
// processor core shared types
package cpu_pkg;

	localparam int INSTR_BYTES = 4;

	// byte address into the shared ram
	typedef logic [15:0] addr_t;
	typedef logic [7:0] byte_t;
	// instructions per run
	typedef logic [7:0] count_t;

	typedef enum logic [7:0] {
		OP_LOAD      = 8'd1,
		OP_JUMP_BACK = 8'd2,
		OP_STORE     = 8'd3,
		OP_ADD       = 8'd4,
		OP_JUMP_FWD  = 8'd5,
		OP_ADDNUM    = 8'd6,
		OP_SET       = 8'd9
	} opcode_t;

	typedef enum logic [1:0] {
		ALU_ADD,
		ALU_ADDNUM,
		ALU_SET
	} alu_op_t;

endpackage

//--- cpu_core.f
common/cpu_pkg.sv
fetch/fetch_decode.sv
execute/block_transfer.sv
execute/block_alu.sv
logic/ram_port_arbiter.sv
logic/register_file.sv
logic/cpu_core.sv
verif/cpu_core_sva.sv
verif/cpu_core_tb.sv

//--- execute/block_alu.sv
// byte serial alu over register spans
module block_alu #(
	parameter int REG_COUNT = 64
) (
	input  logic                         ram_clk,
	input  logic                         stage3_read,
	input  logic                         alu_start,
	input  cpu_pkg::alu_op_t             alu_op,
	input  cpu_pkg::byte_t               alu_src,
	input  cpu_pkg::byte_t               alu_dst,
	input  cpu_pkg::byte_t               alu_len,
	input  cpu_pkg::byte_t               alu_imm,
	output logic                         alu_done,
	output logic                         reg_req,
	output logic                         reg_we,
	output logic [$clog2(REG_COUNT)-1:0] reg_idx,
	output cpu_pkg::byte_t               reg_wdata,
	input  logic                         reg_ready,
	input  cpu_pkg::byte_t               reg_rdata
);
	import cpu_pkg::*;

	localparam int IDX_W = $clog2(REG_COUNT);
	typedef logic [IDX_W-1:0] reg_idx_t;

	typedef enum logic [2:0] {
		A_IDLE,
		A_RD_ISSUE,
		A_RD_WAIT,
		A_WR_ISSUE,
		A_WR_WAIT
	} alu_state_t;

	alu_state_t state;
	alu_op_t op_q;
	byte_t src_q;
	byte_t dst_q;
	byte_t len_q;
	byte_t imm_q;
	byte_t cnt;
	byte_t result_q;
	byte_t addend;

	// add doubles the source byte
	assign addend = (op_q == ALU_ADD) ? reg_rdata : imm_q;
	assign reg_idx = reg_idx_t'(reg_we ? dst_q + cnt : src_q + cnt);
	assign reg_wdata = result_q;

	always_ff @(posedge ram_clk or posedge stage3_read) begin
		if (stage3_read) begin
			state <= A_IDLE;
			cnt <= '0;
			reg_req <= 1'b0;
			reg_we <= 1'b0;
			alu_done <= 1'b0;
		end else begin
			alu_done <= 1'b0;
			case (state)
				A_IDLE: begin
					if (alu_start) begin
						cnt <= '0;
						if (alu_len == '0) begin
							alu_done <= 1'b1;
						end else begin
							state <= (alu_op == ALU_SET) ? A_WR_ISSUE : A_RD_ISSUE;
						end
					end
				end
				A_RD_ISSUE: begin
					reg_req <= 1'b1;
					reg_we <= 1'b0;
					state <= A_RD_WAIT;
				end
				A_RD_WAIT: begin
					if (reg_ready) begin
						reg_req <= 1'b0;
						state <= A_WR_ISSUE;
					end
				end
				A_WR_ISSUE: begin
					reg_req <= 1'b1;
					reg_we <= 1'b1;
					state <= A_WR_WAIT;
				end
				default: begin
					if (reg_ready) begin
						reg_req <= 1'b0;
						reg_we <= 1'b0;
						if ((cnt + 1'b1) == len_q) begin
							alu_done <= 1'b1;
							state <= A_IDLE;
						end else begin
							cnt <= cnt + 1'b1;
							state <= (op_q == ALU_SET) ? A_WR_ISSUE : A_RD_ISSUE;
						end
					end
				end
			endcase
		end
	end

	always_ff @(posedge ram_clk) begin
		if (state == A_IDLE && alu_start) begin
			op_q <= alu_op;
			src_q <= alu_src;
			dst_q <= alu_dst;
			len_q <= alu_len;
			imm_q <= alu_imm;
			// set writes the immediate, which is zero
			result_q <= alu_imm;
		end
		if (state == A_RD_WAIT && reg_ready) begin
			result_q <= reg_rdata + addend;
		end
	end

endmodule

//--- execute/block_transfer.sv
// block copy between ram and registers
module block_transfer #(
	parameter int REG_COUNT = 64
) (
	input  logic                         ram_clk,
	input  logic                         stage3_read,
	input  logic                         xfer_start,
	input  logic                         xfer_store,
	input  cpu_pkg::byte_t               xfer_reg,
	input  cpu_pkg::byte_t               xfer_len,
	input  cpu_pkg::byte_t               xfer_addr,
	output logic                         xfer_done,
	output logic                         mem_req,
	output logic                         mem_we,
	output cpu_pkg::addr_t               mem_addr,
	output cpu_pkg::byte_t               mem_wdata,
	input  logic                         mem_ready,
	input  cpu_pkg::byte_t               mem_rdata,
	output logic                         reg_req,
	output logic                         reg_we,
	output logic [$clog2(REG_COUNT)-1:0] reg_idx,
	output cpu_pkg::byte_t               reg_wdata,
	input  logic                         reg_ready,
	input  cpu_pkg::byte_t               reg_rdata
);
	import cpu_pkg::*;

	localparam int IDX_W = $clog2(REG_COUNT);
	typedef logic [IDX_W-1:0] reg_idx_t;

	typedef enum logic [1:0] {
		T_IDLE,
		T_READ,
		T_WRITE
	} xfer_state_t;

	xfer_state_t state;
	logic store_q;
	byte_t cnt;
	byte_t reg_base;
	byte_t addr_base;
	byte_t len_q;
	byte_t data_q;
	logic rd_ready;
	logic wr_ready;

	// store reads registers and writes ram, load the other way
	assign rd_ready = store_q ? reg_ready : mem_ready;
	assign wr_ready = store_q ? mem_ready : reg_ready;
	assign mem_we = store_q;
	assign reg_we = !store_q;
	assign mem_addr = addr_t'(addr_base) + addr_t'(cnt);
	assign reg_idx = reg_idx_t'(reg_base + cnt);
	assign mem_wdata = data_q;
	assign reg_wdata = data_q;

	always_ff @(posedge ram_clk or posedge stage3_read) begin
		if (stage3_read) begin
			state <= T_IDLE;
			store_q <= 1'b0;
			cnt <= '0;
			mem_req <= 1'b0;
			reg_req <= 1'b0;
			xfer_done <= 1'b0;
		end else begin
			xfer_done <= 1'b0;
			case (state)
				T_IDLE: begin
					if (xfer_start) begin
						store_q <= xfer_store;
						cnt <= '0;
						if (xfer_len == '0) begin
							xfer_done <= 1'b1;
						end else begin
							mem_req <= !xfer_store;
							reg_req <= xfer_store;
							state <= T_READ;
						end
					end
				end
				T_READ: begin
					if (rd_ready) begin
						// drop the read side, request the write side
						mem_req <= store_q;
						reg_req <= !store_q;
						state <= T_WRITE;
					end
				end
				default: begin
					if (wr_ready) begin
						if ((cnt + 1'b1) == len_q) begin
							mem_req <= 1'b0;
							reg_req <= 1'b0;
							xfer_done <= 1'b1;
							state <= T_IDLE;
						end else begin
							cnt <= cnt + 1'b1;
							mem_req <= !store_q;
							reg_req <= store_q;
							state <= T_READ;
						end
					end
				end
			endcase
		end
	end

	always_ff @(posedge ram_clk) begin
		if (state == T_IDLE && xfer_start) begin
			reg_base <= xfer_reg;
			addr_base <= xfer_addr;
			len_q <= xfer_len;
		end
		if (state == T_READ && rd_ready) begin
			data_q <= store_q ? reg_rdata : mem_rdata;
		end
	end

endmodule

//--- fetch/fetch_decode.sv
// instruction fetch, decode and dispatch
module fetch_decode (
	input  logic             ram_clk,
	input  logic             stage3_read,
	input  logic             run,
	input  cpu_pkg::addr_t   start_pc,
	input  cpu_pkg::count_t  instr_limit,
	output logic             busy,
	output logic             done,
	output logic             fetch_req,
	output cpu_pkg::addr_t   fetch_addr,
	input  logic             fetch_ready,
	input  cpu_pkg::byte_t   fetch_rdata,
	output logic             xfer_start,
	output logic             xfer_store,
	output cpu_pkg::byte_t   xfer_reg,
	output cpu_pkg::byte_t   xfer_len,
	output cpu_pkg::byte_t   xfer_addr,
	input  logic             xfer_done,
	output logic             alu_start,
	output cpu_pkg::alu_op_t alu_op,
	output cpu_pkg::byte_t   alu_src,
	output cpu_pkg::byte_t   alu_dst,
	output cpu_pkg::byte_t   alu_len,
	output cpu_pkg::byte_t   alu_imm,
	input  logic             alu_done
);
	import cpu_pkg::*;

	typedef enum logic [1:0] {
		F_IDLE,
		F_ISSUE,
		F_WAIT,
		F_DECODE
	} fetch_state_t;

	fetch_state_t state;
	addr_t pc;
	addr_t jump_dist;
	count_t limit_q;
	count_t fetched;
	count_t retired;
	byte_t instr [INSTR_BYTES];
	logic [$clog2(INSTR_BYTES)-1:0] bidx;
	opcode_t opcode;
	logic is_jump;
	logic exec_op;
	logic load_slot;
	logic decode_retire;
	logic unit_retire;
	logic pend_valid;
	logic pend_alu;
	logic unit_busy;

	assign opcode = opcode_t'(instr[0]);
	assign is_jump = (opcode == OP_JUMP_FWD) || (opcode == OP_JUMP_BACK);
	assign exec_op = opcode inside {OP_LOAD, OP_STORE, OP_ADD, OP_ADDNUM, OP_SET};
	assign jump_dist = addr_t'(instr[1]) * addr_t'(INSTR_BYTES);
	assign fetch_addr = pc + addr_t'(bidx);
	assign load_slot = (state == F_DECODE) && exec_op;
	// jumps and unknown codes retire at decode
	assign decode_retire = (state == F_DECODE) && !exec_op;
	assign unit_retire = xfer_done || alu_done;

	always_ff @(posedge ram_clk or posedge stage3_read) begin
		if (stage3_read) begin
			state <= F_IDLE;
			pc <= '0;
			fetched <= '0;
			bidx <= '0;
			fetch_req <= 1'b0;
		end else begin
			case (state)
				F_IDLE: begin
					if (run && !busy) begin
						pc <= start_pc;
						fetched <= '0;
						bidx <= '0;
						state <= (instr_limit == '0) ? F_IDLE : F_ISSUE;
					end
				end
				F_ISSUE: begin
					if (bidx == '0 && fetched == limit_q) begin
						state <= F_IDLE;
					end else if (!pend_valid) begin
						// slot free, fetch the next byte
						fetch_req <= 1'b1;
						state <= F_WAIT;
					end
				end
				F_WAIT: begin
					if (fetch_ready) begin
						fetch_req <= 1'b0;
						if (bidx == INSTR_BYTES - 1 || (bidx == 1 && is_jump)) begin
							state <= F_DECODE;
						end else begin
							bidx <= bidx + 1'b1;
							state <= F_ISSUE;
						end
					end
				end
				default: begin
					fetched <= fetched + 1'b1;
					bidx <= '0;
					state <= F_ISSUE;
					case (opcode)
						OP_JUMP_FWD: pc <= pc + jump_dist;
						OP_JUMP_BACK: pc <= pc - jump_dist;
						default: pc <= pc + addr_t'(INSTR_BYTES);
					endcase
				end
			endcase
		end
	end

	// instruction bytes and decoded slot fields
	always_ff @(posedge ram_clk) begin
		if (state == F_WAIT && fetch_ready) begin
			instr[bidx] <= fetch_rdata;
		end
		if (load_slot) begin
			xfer_store <= (opcode == OP_STORE);
			xfer_reg <= instr[1];
			xfer_len <= instr[2];
			xfer_addr <= instr[3];
			alu_src <= instr[1];
			case (opcode)
				OP_ADD: begin
					alu_op <= ALU_ADD;
					alu_dst <= instr[2];
					alu_len <= instr[3];
					alu_imm <= '0;
				end
				OP_ADDNUM: begin
					alu_op <= ALU_ADDNUM;
					alu_dst <= instr[2];
					alu_len <= instr[3];
					alu_imm <= instr[1];
				end
				default: begin
					alu_op <= ALU_SET;
					alu_dst <= instr[1];
					alu_len <= instr[2];
					alu_imm <= '0;
				end
			endcase
		end
	end

	always_ff @(posedge ram_clk or posedge stage3_read) begin
		if (stage3_read) begin
			pend_valid <= 1'b0;
			pend_alu <= 1'b0;
			unit_busy <= 1'b0;
			xfer_start <= 1'b0;
			alu_start <= 1'b0;
		end else begin
			xfer_start <= 1'b0;
			alu_start <= 1'b0;
			if (load_slot) begin
				pend_valid <= 1'b1;
				pend_alu <= !(opcode == OP_LOAD || opcode == OP_STORE);
			end else if (pend_valid && !unit_busy) begin
				pend_valid <= 1'b0;
				unit_busy <= 1'b1;
				if (pend_alu) begin
					alu_start <= 1'b1;
				end else begin
					xfer_start <= 1'b1;
				end
			end
			if (unit_retire) begin
				unit_busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge ram_clk or posedge stage3_read) begin
		if (stage3_read) begin
			busy <= 1'b0;
			done <= 1'b0;
			limit_q <= '0;
			retired <= '0;
		end else begin
			done <= 1'b0;
			if (run && !busy) begin
				busy <= 1'b1;
				limit_q <= instr_limit;
				retired <= '0;
				// empty run finishes at once
				done <= (instr_limit == '0);
			end else if (busy) begin
				retired <= retired + count_t'(decode_retire) + count_t'(unit_retire);
				if (done) begin
					busy <= 1'b0;
				end else if (retired == limit_q) begin
					done <= 1'b1;
				end
			end
		end
	end

endmodule

//--- logic/cpu_core.sv
// byte processor core
module cpu_core #(
	parameter int REG_COUNT = 64
) (
	input  logic            ram_clk,
	input  logic            stage3_read,
	input  logic            run,
	input  cpu_pkg::addr_t  start_pc,
	input  cpu_pkg::count_t instr_limit,
	output logic            busy,
	output logic            done,
	input  logic            host_req,
	input  logic            host_we,
	input  cpu_pkg::addr_t  host_addr,
	input  cpu_pkg::byte_t  host_wdata,
	output logic            host_ready,
	output cpu_pkg::byte_t  host_rdata
);
	import cpu_pkg::*;

	localparam int IDX_W = $clog2(REG_COUNT);
	typedef logic [IDX_W-1:0] reg_idx_t;

	// instruction fetch path
	logic fetch_req;
	addr_t fetch_addr;
	logic fetch_ready;
	byte_t fetch_rdata;

	// dispatch to the execute units
	logic xfer_start;
	logic xfer_store;
	byte_t xfer_reg;
	byte_t xfer_len;
	byte_t xfer_addr;
	logic xfer_done;
	logic alu_start;
	alu_op_t alu_op;
	byte_t alu_src;
	byte_t alu_dst;
	byte_t alu_len;
	byte_t alu_imm;
	logic alu_done;

	// transfer ram port
	logic mem_req;
	logic mem_we;
	addr_t mem_addr;
	byte_t mem_wdata;
	logic mem_ready;
	byte_t mem_rdata;

	// register ports
	logic xfer_reg_req;
	logic xfer_reg_we;
	reg_idx_t xfer_reg_idx;
	byte_t xfer_reg_wdata;
	logic xfer_reg_ready;
	byte_t xfer_reg_rdata;
	logic alu_reg_req;
	logic alu_reg_we;
	reg_idx_t alu_reg_idx;
	byte_t alu_reg_wdata;
	logic alu_reg_ready;
	byte_t alu_reg_rdata;

	fetch_decode u_fetch_decode (.*);

	block_transfer #(
		.REG_COUNT(REG_COUNT)
	) u_block_transfer (
		.reg_req   (xfer_reg_req),
		.reg_we    (xfer_reg_we),
		.reg_idx   (xfer_reg_idx),
		.reg_wdata (xfer_reg_wdata),
		.reg_ready (xfer_reg_ready),
		.reg_rdata (xfer_reg_rdata),
		.*
	);

	block_alu #(
		.REG_COUNT(REG_COUNT)
	) u_block_alu (
		.reg_req   (alu_reg_req),
		.reg_we    (alu_reg_we),
		.reg_idx   (alu_reg_idx),
		.reg_wdata (alu_reg_wdata),
		.reg_ready (alu_reg_ready),
		.reg_rdata (alu_reg_rdata),
		.*
	);

	ram_port_arbiter u_ram_port_arbiter (.*);

	register_file #(
		.REG_COUNT(REG_COUNT)
	) u_register_file (.*);

endmodule

//--- logic/ram_port_arbiter.sv
// shared byte ram with port arbiter
module ram_port_arbiter (
	input  logic           ram_clk,
	input  logic           stage3_read,
	input  logic           mem_req,
	input  logic           mem_we,
	input  cpu_pkg::addr_t mem_addr,
	input  cpu_pkg::byte_t mem_wdata,
	output logic           mem_ready,
	output cpu_pkg::byte_t mem_rdata,
	input  logic           fetch_req,
	input  cpu_pkg::addr_t fetch_addr,
	output logic           fetch_ready,
	output cpu_pkg::byte_t fetch_rdata,
	input  logic           host_req,
	input  logic           host_we,
	input  cpu_pkg::addr_t host_addr,
	input  cpu_pkg::byte_t host_wdata,
	output logic           host_ready,
	output cpu_pkg::byte_t host_rdata
);
	import cpu_pkg::*;

	typedef enum logic [2:0] {
		R_IDLE,
		R_XFER,
		R_FETCH,
		R_HOST,
		R_RESP
	} arb_state_t;

	arb_state_t state;
	byte_t mem_array [2**$bits(addr_t)];
	logic acc_en;
	logic acc_we;
	addr_t acc_addr;
	byte_t acc_wdata;
	byte_t rdata_q;

	// signals of the granted requester, held steady by it
	always_comb begin
		acc_en = 1'b1;
		acc_we = 1'b0;
		acc_addr = mem_addr;
		acc_wdata = mem_wdata;
		case (state)
			R_XFER: acc_we = mem_we;
			R_FETCH: acc_addr = fetch_addr;
			R_HOST: begin
				acc_we = host_we;
				acc_addr = host_addr;
				acc_wdata = host_wdata;
			end
			default: acc_en = 1'b0;
		endcase
	end

	always_ff @(posedge ram_clk) begin
		if (acc_en) begin
			if (acc_we) begin
				mem_array[acc_addr] <= acc_wdata;
			end else begin
				rdata_q <= mem_array[acc_addr];
			end
		end
	end

	assign mem_rdata = rdata_q;
	assign fetch_rdata = rdata_q;
	assign host_rdata = rdata_q;

	always_ff @(posedge ram_clk or posedge stage3_read) begin
		if (stage3_read) begin
			state <= R_IDLE;
			mem_ready <= 1'b0;
			fetch_ready <= 1'b0;
			host_ready <= 1'b0;
		end else begin
			mem_ready <= 1'b0;
			fetch_ready <= 1'b0;
			host_ready <= 1'b0;
			case (state)
				R_IDLE: begin
					// transfer first, host last
					if (mem_req) begin
						state <= R_XFER;
					end else if (fetch_req) begin
						state <= R_FETCH;
					end else if (host_req) begin
						state <= R_HOST;
					end
				end
				R_XFER: begin
					mem_ready <= 1'b1;
					state <= R_RESP;
				end
				R_FETCH: begin
					fetch_ready <= 1'b1;
					state <= R_RESP;
				end
				R_HOST: begin
					host_ready <= 1'b1;
					state <= R_RESP;
				end
				default: state <= R_IDLE;
			endcase
		end
	end

endmodule

//--- logic/register_file.sv
// byte register file, one access port
module register_file #(
	parameter int REG_COUNT = 64
) (
	input  logic                         ram_clk,
	input  logic                         stage3_read,
	input  logic                         xfer_reg_req,
	input  logic                         xfer_reg_we,
	input  logic [$clog2(REG_COUNT)-1:0] xfer_reg_idx,
	input  cpu_pkg::byte_t               xfer_reg_wdata,
	output logic                         xfer_reg_ready,
	output cpu_pkg::byte_t               xfer_reg_rdata,
	input  logic                         alu_reg_req,
	input  logic                         alu_reg_we,
	input  logic [$clog2(REG_COUNT)-1:0] alu_reg_idx,
	input  cpu_pkg::byte_t               alu_reg_wdata,
	output logic                         alu_reg_ready,
	output cpu_pkg::byte_t               alu_reg_rdata
);
	import cpu_pkg::*;

	localparam int IDX_W = $clog2(REG_COUNT);
	typedef logic [IDX_W-1:0] reg_idx_t;

	byte_t regs [REG_COUNT];
	logic xfer_sel;
	logic alu_sel;
	logic acc_we;
	reg_idx_t acc_idx;
	byte_t acc_wdata;
	byte_t rdata_q;

	// a request not yet answered
	assign xfer_sel = xfer_reg_req && !xfer_reg_ready;
	assign alu_sel = alu_reg_req && !alu_reg_ready && !xfer_sel;
	assign acc_we = xfer_sel ? xfer_reg_we : alu_reg_we;
	assign acc_idx = xfer_sel ? xfer_reg_idx : alu_reg_idx;
	assign acc_wdata = xfer_sel ? xfer_reg_wdata : alu_reg_wdata;
	assign xfer_reg_rdata = rdata_q;
	assign alu_reg_rdata = rdata_q;

	always_ff @(posedge ram_clk or posedge stage3_read) begin
		if (stage3_read) begin
			for (int i = 0; i < REG_COUNT; i++) begin
				regs[i] <= '0;
			end
			rdata_q <= '0;
			xfer_reg_ready <= 1'b0;
			alu_reg_ready <= 1'b0;
		end else begin
			xfer_reg_ready <= xfer_sel;
			alu_reg_ready <= alu_sel;
			if (xfer_sel || alu_sel) begin
				if (acc_we) begin
					regs[acc_idx] <= acc_wdata;
				end
				rdata_q <= regs[acc_idx];
			end
		end
	end

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the core testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module cpu_core_tb -f cpu_core.f -o cpu_core_sim

# an aborted run counts as a failure
./obj_dir/cpu_core_sim > sim.log 2>&1 || echo "TEST FAILED" >> sim.log
cat sim.log

if grep -q "TEST FAILED" sim.log; then
	exit 1
fi
exit 0

//--- verif/cpu_core_sva.sv
// core handshake assertions
module cpu_core_sva (
	input logic ram_clk,
	input logic stage3_read,
	input logic busy,
	input logic done,
	input logic host_ready
);
	timeunit 1ns;
	timeprecision 100ps;

	done_one_cycle: assert property (@(posedge ram_clk) disable iff (stage3_read)
		done |=> !done)
		else $error("done stayed high for more than one cycle");

	host_ready_one_cycle: assert property (@(posedge ram_clk) disable iff (stage3_read)
		host_ready |=> !host_ready)
		else $error("host_ready stayed high for more than one cycle");

	// run ends the cycle after done
	busy_after_done: assert property (@(posedge ram_clk) disable iff (stage3_read)
		done |=> !busy)
		else $error("busy still high after done");

	busy_low_after_reset: assert property (@(posedge ram_clk)
		$fell(stage3_read) |-> !busy && !done)
		else $error("busy or done high right after reset");

endmodule

bind cpu_core cpu_core_sva u_cpu_core_sva (
	.ram_clk     (ram_clk),
	.stage3_read (stage3_read),
	.busy        (busy),
	.done        (done),
	.host_ready  (host_ready)
);

//--- verif/cpu_core_tb.sv
// processor core testbench
module cpu_core_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import cpu_pkg::*;

	localparam int REG_COUNT = 64;
	localparam int RAND_ROUNDS = 6;
	// instructions and host accesses of all tests together
	localparam int TOTAL_INSTR = 40;
	localparam int HOST_ACCESSES = 450;
	localparam int CYCLE_LIMIT = 200 * TOTAL_INSTR + 20 * HOST_ACCESSES;

	logic ram_clk;
	logic stage3_read;
	logic run;
	addr_t start_pc;
	count_t instr_limit;
	logic busy;
	logic done;
	logic host_req;
	logic host_we;
	addr_t host_addr;
	byte_t host_wdata;
	logic host_ready;
	byte_t host_rdata;

	// model copies of ram and registers
	byte_t ref_mem [65536];
	byte_t ref_regs [REG_COUNT];
	int errors = 0;
	int checks = 0;
	int cycles = 0;
	int done_count = 0;
	integer seed;

	cpu_core #(
		.REG_COUNT(REG_COUNT)
	) u_cpu_core (.*);

	initial begin
		ram_clk = 1'b0;
		forever begin
			#4 ram_clk = ~ram_clk;
		end
	end

	initial begin
		while (cycles < CYCLE_LIMIT) begin
			@(posedge ram_clk);
			cycles++;
		end
		$display("timeout: no finish within %0d clock cycles", CYCLE_LIMIT);
		$display("TEST FAILED");
		$finish;
	end

	always @(negedge ram_clk) begin
		if (done) begin
			done_count++;
		end
	end

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("Error %s got %0h expected %0h", name, got, expected);
		end
	endtask

	function automatic void ref_run(input addr_t start, input count_t limit);
		addr_t pc;
		byte_t b0;
		byte_t b1;
		byte_t b2;
		byte_t b3;
		pc = start;
		for (int n = 0; n < int'(limit); n++) begin
			b0 = ref_mem[pc];
			b1 = ref_mem[pc + 16'd1];
			b2 = ref_mem[pc + 16'd2];
			b3 = ref_mem[pc + 16'd3];
			case (b0)
				OP_LOAD: begin
					for (int i = 0; i < b2; i++) begin
						ref_regs[(b1 + i) % REG_COUNT] = ref_mem[b3 + i];
					end
				end
				OP_STORE: begin
					for (int i = 0; i < b2; i++) begin
						ref_mem[b3 + i] = ref_regs[(b1 + i) % REG_COUNT];
					end
				end
				OP_ADD: begin
					for (int i = 0; i < b3; i++) begin
						ref_regs[(b2 + i) % REG_COUNT] = 8'(2 * ref_regs[(b1 + i) % REG_COUNT]);
					end
				end
				OP_ADDNUM: begin
					for (int i = 0; i < b3; i++) begin
						ref_regs[(b2 + i) % REG_COUNT] = 8'(ref_regs[(b1 + i) % REG_COUNT] + b1);
					end
				end
				OP_SET: begin
					for (int i = 0; i < b2; i++) begin
						ref_regs[(b1 + i) % REG_COUNT] = 8'h00;
					end
				end
				default: begin
				end
			endcase
			case (b0)
				OP_JUMP_FWD: pc = pc + 16'(b1) * 16'd4;
				OP_JUMP_BACK: pc = pc - 16'(b1) * 16'd4;
				default: pc = pc + 16'd4;
			endcase
		end
	endfunction

	task automatic host_access(input logic we, input addr_t addr, input byte_t wdata,
			output byte_t rdata);
		@(negedge ram_clk);
		host_req = 1'b1;
		host_we = we;
		host_addr = addr;
		host_wdata = wdata;
		do begin
			@(negedge ram_clk);
		end while (!host_ready);
		rdata = host_rdata;
		host_req = 1'b0;
		host_we = 1'b0;
	endtask

	task automatic write_byte(input addr_t addr, input byte_t data);
		byte_t unused;
		host_access(1'b1, addr, data, unused);
		ref_mem[addr] = data;
	endtask

	task automatic check_byte(input addr_t addr);
		byte_t got;
		host_access(1'b0, addr, 8'h00, got);
		check_value($sformatf("host_rdata[%h]", addr), got, ref_mem[addr]);
	endtask

	task automatic put_instr(input addr_t addr, input byte_t b0, input byte_t b1,
			input byte_t b2, input byte_t b3);
		write_byte(addr, b0);
		write_byte(addr + 16'd1, b1);
		write_byte(addr + 16'd2, b2);
		write_byte(addr + 16'd3, b3);
	endtask

	task automatic start_run(input addr_t pc, input count_t limit);
		@(negedge ram_clk);
		run = 1'b1;
		start_pc = pc;
		instr_limit = limit;
		@(negedge ram_clk);
		run = 1'b0;
	endtask

	task automatic wait_done();
		while (!done) begin
			@(negedge ram_clk);
		end
		// busy falls one cycle after done
		@(negedge ram_clk);
	endtask

	task automatic run_and_model(input addr_t pc, input count_t limit);
		start_run(pc, limit);
		wait_done();
		ref_run(pc, limit);
	endtask

	initial begin
		addr_t addr;
		int len;
		int rs;
		int rd;
		int count_before;
		seed = 63838;
		stage3_read = 1'b1;
		run = 1'b0;
		start_pc = '0;
		instr_limit = '0;
		host_req = 1'b0;
		host_we = 1'b0;
		host_addr = '0;
		host_wdata = '0;
		for (int i = 0; i < REG_COUNT; i++) begin
			ref_regs[i] = 8'h00;
		end
		repeat (3) @(posedge ram_clk);
		@(negedge ram_clk);
		stage3_read = 1'b0;

		// idle outputs, then host port write and read back
		@(negedge ram_clk);
		check_value("busy", busy, 0);
		check_value("done", done, 0);
		check_value("host_ready", host_ready, 0);
		for (int i = 0; i < 16; i++) begin
			addr = 16'h8000 + 16'(i * 16'h0413);
			write_byte(addr, addr[15:8] ^ addr[7:0] ^ 8'h5a);
		end
		for (int i = 0; i < 16; i++) begin
			check_byte(16'h8000 + 16'(i * 16'h0413));
		end

		// block copy through registers
		for (int i = 0; i < 8; i++) begin
			write_byte(16'h0010 + 16'(i), 8'(8'h31 + i * 7));
		end
		put_instr(16'h0100, OP_LOAD, 8'd4, 8'd8, 8'h10);
		put_instr(16'h0104, OP_STORE, 8'd4, 8'd8, 8'h40);
		run_and_model(16'h0100, 8'd2);
		for (int i = 0; i < 8; i++) begin
			check_byte(16'h0040 + 16'(i));
		end

		// add, addnum and set
		for (int i = 0; i < 8; i++) begin
			write_byte(16'h0020 + 16'(i), 8'(8'h90 + i * 13));
		end
		put_instr(16'h0140, OP_LOAD, 8'd10, 8'd8, 8'h20);
		put_instr(16'h0144, OP_ADD, 8'd10, 8'd20, 8'd8);
		put_instr(16'h0148, OP_ADDNUM, 8'd10, 8'd30, 8'd8);
		put_instr(16'h014c, OP_SET, 8'd12, 8'd3, 8'd0);
		put_instr(16'h0150, OP_STORE, 8'd20, 8'd8, 8'h60);
		put_instr(16'h0154, OP_STORE, 8'd30, 8'd8, 8'h70);
		put_instr(16'h0158, OP_STORE, 8'd10, 8'd8, 8'h80);
		run_and_model(16'h0140, 8'd7);
		for (int i = 0; i < 8; i++) begin
			check_byte(16'h0060 + 16'(i));
			check_byte(16'h0070 + 16'(i));
			check_byte(16'h0080 + 16'(i));
		end

		// forward jump skips a store, backward jump repeats the doubling
		write_byte(16'h0030, 8'h11);
		write_byte(16'h0031, 8'h22);
		write_byte(16'h0090, 8'h00);
		write_byte(16'h0091, 8'h00);
		put_instr(16'h0180, OP_LOAD, 8'd40, 8'd2, 8'h30);
		put_instr(16'h0184, OP_JUMP_FWD, 8'd2, 8'd0, 8'd0);
		put_instr(16'h0188, OP_STORE, 8'd41, 8'd1, 8'h90);
		put_instr(16'h018c, OP_ADD, 8'd40, 8'd40, 8'd1);
		put_instr(16'h0190, OP_STORE, 8'd40, 8'd1, 8'h91);
		put_instr(16'h0194, OP_JUMP_BACK, 8'd2, 8'd0, 8'd0);
		run_and_model(16'h0180, 8'd7);
		check_byte(16'h0090);
		check_byte(16'h0091);

		// limit below program length, second run while busy
		for (int i = 0; i < 4; i++) begin
			write_byte(16'h0034 + 16'(i), 8'(8'hc0 + i));
			write_byte(16'h00a0 + 16'(i), 8'hee);
		end
		put_instr(16'h01c0, OP_LOAD, 8'd50, 8'd4, 8'h34);
		put_instr(16'h01c4, 8'h0f, 8'd0, 8'd0, 8'd0);
		put_instr(16'h01c8, OP_STORE, 8'd50, 8'd1, 8'ha0);
		put_instr(16'h01cc, OP_STORE, 8'd51, 8'd1, 8'ha1);
		put_instr(16'h01d0, OP_STORE, 8'd52, 8'd1, 8'ha2);
		put_instr(16'h01d4, OP_STORE, 8'd53, 8'd1, 8'ha3);
		put_instr(16'h01e0, OP_STORE, 8'd52, 8'd2, 8'ha0);
		count_before = done_count;
		start_run(16'h01c0, 8'd4);
		while (!busy) begin
			@(negedge ram_clk);
		end
		start_run(16'h01e0, 8'd1);
		wait_done();
		ref_run(16'h01c0, 8'd4);
		repeat (20) @(negedge ram_clk);
		check_value("done pulses", done_count - count_before, 1);
		for (int i = 0; i < 4; i++) begin
			check_byte(16'h00a0 + 16'(i));
		end
		count_before = done_count;
		start_run(16'h01c0, 8'd0);
		wait_done();
		repeat (5) @(negedge ram_clk);
		check_value("done pulses", done_count - count_before, 1);

		// random spans
		for (int r = 0; r < RAND_ROUNDS; r++) begin
			len = 1 + ($unsigned($random(seed)) % 16);
			rs = $unsigned($random(seed)) % REG_COUNT;
			rd = $unsigned($random(seed)) % REG_COUNT;
			for (int i = 0; i < len; i++) begin
				write_byte(16'h00c0 + 16'(i), 8'($random(seed)));
			end
			put_instr(16'h0200, OP_LOAD, 8'(rs), 8'(len), 8'hc0);
			put_instr(16'h0204, OP_ADD, 8'(rs), 8'(rd), 8'(len));
			put_instr(16'h0208, OP_STORE, 8'(rd), 8'(len), 8'he0);
			run_and_model(16'h0200, 8'd3);
			for (int i = 0; i < len; i++) begin
				check_byte(16'h00e0 + 16'(i));
			end
		end

		$display("checks: %0d errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule
